// File: hw/ecc_mem_defines.svh
`ifndef ECC_MEM_DEFINES_SVH
`define ECC_MEM_DEFINES_SVH

// data word width
`define ECC_MEM_DATA_W 32

// six hamming bits plus the overall parity bit
`define ECC_MEM_CHECK_W 7

// scratch array geometry, one codeword per address
`define ECC_MEM_ADDR_W 6
`define ECC_MEM_DEPTH 64

// peer requesters sharing the array
`define ECC_MEM_NUM_PORTS 2

`endif

// File: hw/ecc_mem_pkg.sv
`default_nettype none

`include "ecc_mem_defines.svh"

package ecc_mem_pkg;

   typedef logic [$clog2(`ECC_MEM_NUM_PORTS)-1:0] port_id_t;

   typedef struct packed {
      logic [`ECC_MEM_CHECK_W-1:0] check;
      logic [`ECC_MEM_DATA_W-1:0]  data;
   } codeword_t;

   typedef struct packed {
      logic                       write;
      logic [`ECC_MEM_ADDR_W-1:0] addr;
      logic [`ECC_MEM_DATA_W-1:0] wdata;
      codeword_t                  flip;   // xored into the stored word
   } mem_req_t;

   typedef struct packed {
      port_id_t port;
      mem_req_t req;
   } mem_cmd_t;

   typedef struct packed {
      port_id_t                   port;
      logic [`ECC_MEM_DATA_W-1:0] rdata;
      logic                       single_err;
      logic                       double_err;
   } mem_rsp_t;

   // data bits sit at the non power of two positions 3,5,6,7,9.. of the codeword;
   // hamming bit k covers every data position with bit k set
   function automatic logic [`ECC_MEM_CHECK_W-1:0] ecc_check_bits(
      input logic [`ECC_MEM_DATA_W-1:0] data);
      logic [`ECC_MEM_CHECK_W-1:0] chk;
      int unsigned                 d;
      chk = '0;
      d   = 0;
      for (int unsigned p = 1; p < `ECC_MEM_DATA_W + `ECC_MEM_CHECK_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            for (int k = 0; k < `ECC_MEM_CHECK_W - 1; k++) begin
               if (p[k]) chk[k] = chk[k] ^ data[d];
            end
            d++;
         end
      end
      chk[`ECC_MEM_CHECK_W-1] = ^{data, chk[`ECC_MEM_CHECK_W-2:0]};   // overall parity
      return chk;
   endfunction

   // low six bits name the failing position, top bit is overall parity
   function automatic logic [`ECC_MEM_CHECK_W-1:0] ecc_syndrome(input codeword_t cw);
      logic [`ECC_MEM_CHECK_W-1:0] recomputed;
      logic [`ECC_MEM_CHECK_W-1:0] syn;
      recomputed = ecc_check_bits(cw.data);
      syn = recomputed ^ cw.check;
      syn[`ECC_MEM_CHECK_W-1] = ^{cw.data, cw.check};   // zero for a clean word
      return syn;
   endfunction

endpackage

`default_nettype wire

// File: hw/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defines.svh"

module req_arbiter
   import ecc_mem_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_l,
   input  logic [`ECC_MEM_NUM_PORTS-1:0] req,
   input  mem_req_t                      req_data [`ECC_MEM_NUM_PORTS],
   output logic [`ECC_MEM_NUM_PORTS-1:0] gnt,
   output logic                          cmd_valid,
   output mem_cmd_t                      cmd
);

   logic     taken;     // a lower port already won this cycle
   logic     any_req;
   port_id_t gnt_id;

   // find first one-hot from the bottom so port 0 wins a tie
   always_comb begin
      taken = 1'b0;
      gnt   = '0;
      for (int i = 0; i < `ECC_MEM_NUM_PORTS; i++) begin
         gnt[i] = req[i] & ~taken;
         taken  = taken | req[i];
      end
   end

   // winner index for the tag and the payload mux
   always_comb begin
      gnt_id = '0;
      for (int i = 0; i < `ECC_MEM_NUM_PORTS; i++) begin
         if (gnt[i]) gnt_id = port_id_t'(i);
      end
   end

   assign any_req = |req;   // memory takes one request every cycle

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         cmd_valid <= 1'b0;
      end else begin
         cmd_valid <= any_req;
      end
   end

   // payload only loads when something was granted
   always_ff @(posedge clk) begin
      if (any_req) begin
         cmd.port <= gnt_id;
         cmd.req  <= req_data[gnt_id];
      end
   end

   // grant is one-hot or idle and never goes to a port that is not asking
   a_gnt_legal: assert property (@(posedge clk) disable iff (!rst_l)
      $onehot0(gnt) && ((gnt & ~req) == '0));

endmodule

`default_nettype wire

// File: hw/ecc_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defines.svh"

module ecc_store
   import ecc_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst_l,
   input  logic      cmd_valid,
   input  mem_cmd_t  cmd,
   output logic      rd_valid,
   output port_id_t  rd_port,
   output codeword_t rd_word
);

   codeword_t mem [`ECC_MEM_DEPTH];
   codeword_t enc_word;
   codeword_t wr_word;
   logic      wr_en;
   logic      rd_en;

   assign wr_en = cmd_valid & cmd.req.write;
   assign rd_en = cmd_valid & ~cmd.req.write;

   // encoder
   assign enc_word.data  = cmd.req.wdata;
   assign enc_word.check = ecc_check_bits(cmd.req.wdata);

   // a zero flip mask stores the clean word
   assign wr_word = enc_word ^ cmd.req.flip;

   // writes land at the edge after the command, so a read granted
   // one cycle behind a write already sees the new word
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[cmd.req.addr] <= wr_word;
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en;   // writes give no response
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_word <= mem[cmd.req.addr];   // raw codeword for the correction stage
         rd_port <= cmd.port;
      end
   end

   // address from the arbiter must stay inside the array
   a_addr_range: assert property (@(posedge clk) disable iff (!rst_l)
      cmd_valid |-> (int'(cmd.req.addr) < `ECC_MEM_DEPTH));

endmodule

`default_nettype wire

// File: hw/ecc_correct.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defines.svh"

module ecc_correct
   import ecc_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst_l,
   input  logic      rd_valid,
   input  port_id_t  rd_port,
   input  codeword_t rd_word,
   output logic      rsp_valid,
   output mem_rsp_t  rsp
);

   localparam int unsigned CW_W  = `ECC_MEM_DATA_W + `ECC_MEM_CHECK_W;
   localparam int unsigned PAR_B = `ECC_MEM_CHECK_W - 1;

   logic [`ECC_MEM_CHECK_W-1:0] syn;
   logic                        syn_hit;
   logic                        single_err;
   logic                        double_err;
   logic [`ECC_MEM_DATA_W-1:0]  data_fix;
   int unsigned                 d;
   logic                        single_q;
   logic                        double_q;
   port_id_t                    port_q;
   logic [`ECC_MEM_DATA_W-1:0]  rdata_q;

   assign syn     = ecc_syndrome(rd_word);
   assign syn_hit = (syn != '0);

   // odd flip count reads as one error and even nonzero as two
   assign single_err = syn_hit & syn[PAR_B];
   assign double_err = syn_hit & ~syn[PAR_B];

   // walk the codeword positions in the same order as the encoder and
   // flip the data bit the syndrome points at
   // a hit on a check bit position or on the parity bit leaves the data alone
   always_comb begin
      d        = 0;
      data_fix = rd_word.data;
      for (int unsigned p = 1; p < CW_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            if (single_err && (syn[PAR_B-1:0] == p[PAR_B-1:0])) begin
               data_fix[d] = ~rd_word.data[d];
            end
            d++;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rsp_valid <= 1'b0;
         single_q  <= 1'b0;
         double_q  <= 1'b0;
      end else begin
         rsp_valid <= rd_valid;
         single_q  <= rd_valid & single_err;   // flags only mean something with valid
         double_q  <= rd_valid & double_err;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_valid) begin
         port_q  <= rd_port;
         rdata_q <= data_fix;   // meaningless on a double error
      end
   end

   assign rsp = '{port:       port_q,
                  rdata:      rdata_q,
                  single_err: single_q,
                  double_err: double_q};

   // error flags are exclusive and only ride on a valid response
   a_err_flags: assert property (@(posedge clk) disable iff (!rst_l)
      (rsp.single_err || rsp.double_err) |->
         rsp_valid && !(rsp.single_err && rsp.double_err));

endmodule

`default_nettype wire

// File: hw/ecc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defines.svh"

module ecc_mem_top
   import ecc_mem_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_l,
   input  logic [`ECC_MEM_NUM_PORTS-1:0] req,
   input  mem_req_t                      req_data [`ECC_MEM_NUM_PORTS],
   output logic [`ECC_MEM_NUM_PORTS-1:0] gnt,
   output logic                          rsp_valid,
   output mem_rsp_t                      rsp
);

   // arbiter to array
   logic      cmd_valid;
   mem_cmd_t  cmd;

   // array to correction stage
   logic      rd_valid;
   port_id_t  rd_port;
   codeword_t rd_word;

   req_arbiter u_arb (
      .clk       (clk),
      .rst_l     (rst_l),
      .req       (req),
      .req_data  (req_data),
      .gnt       (gnt),
      .cmd_valid (cmd_valid),
      .cmd       (cmd)
   );

   ecc_store u_store (
      .clk       (clk),
      .rst_l     (rst_l),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .rd_valid  (rd_valid),
      .rd_port   (rd_port),
      .rd_word   (rd_word)
   );

   ecc_correct u_correct (
      .clk       (clk),
      .rst_l     (rst_l),
      .rd_valid  (rd_valid),
      .rd_port   (rd_port),
      .rd_word   (rd_word),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

endmodule

`default_nettype wire

// File: verification/ecc_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_defines.svh"

module ecc_mem_tb
   import ecc_mem_pkg::*;
();

   localparam int unsigned CW_W       = `ECC_MEM_DATA_W + `ECC_MEM_CHECK_W;
   localparam int unsigned MAX_CYCLES = 2000;   // roughly 450 cycles of traffic below

   typedef struct {
      int unsigned due;          // cycle whose closing edge samples the response
      mem_rsp_t    rsp;
      logic        check_data;   // data is meaningless after a double flip
   } exp_entry_t;

   logic                          clk = 1'b0;
   logic                          rst_l;
   logic [`ECC_MEM_NUM_PORTS-1:0] req;
   mem_req_t                      req_data [`ECC_MEM_NUM_PORTS];
   logic [`ECC_MEM_NUM_PORTS-1:0] gnt;
   logic                          rsp_valid;
   mem_rsp_t                      rsp;

   // reference model holds the last data and flip mask per address
   logic [`ECC_MEM_DATA_W-1:0] ref_data [`ECC_MEM_DEPTH];
   codeword_t                  ref_flip [`ECC_MEM_DEPTH];
   exp_entry_t                 exp_q [$];
   logic                       exp_valid;
   mem_rsp_t                   exp_rsp;
   logic                       exp_check_data;
   logic                       seen_req;

   logic [`ECC_MEM_ADDR_W-1:0] written_q [$];   // addresses safe to read
   logic [31:0]                rng = 32'hc5c7_ff70;
   int unsigned                cyc = 0;
   int                         errors = 0;
   int                         errors_base = 0;
   int                         tests_run = 0;
   int                         rsp_count = 0;

   ecc_mem_top uut (
      .clk       (clk),
      .rst_l     (rst_l),
      .req       (req),
      .req_data  (req_data),
      .gnt       (gnt),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc == MAX_CYCLES) begin
         $display("timeout after %0d cycles, a grant or response never came", MAX_CYCLES);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] random_word();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // lowest requesting port wins
   function automatic logic [`ECC_MEM_NUM_PORTS-1:0] lowest_request_mask(
      input logic [`ECC_MEM_NUM_PORTS-1:0] r);
      logic [`ECC_MEM_NUM_PORTS-1:0] m;
      m = '0;
      for (int i = `ECC_MEM_NUM_PORTS - 1; i >= 0; i--) begin
         if (r[i]) begin
            m    = '0;
            m[i] = 1'b1;
         end
      end
      return m;
   endfunction

   function automatic mem_req_t build_request(input logic write,
                                              input logic [`ECC_MEM_ADDR_W-1:0] addr,
                                              input logic [`ECC_MEM_DATA_W-1:0] data,
                                              input codeword_t flip);
      mem_req_t r;
      r.write = write;
      r.addr  = addr;
      r.wdata = data;
      r.flip  = flip;
      return r;
   endfunction

   function automatic codeword_t one_bit_flip(input int unsigned pos);
      logic [CW_W-1:0] m;
      m      = '0;
      m[pos] = 1'b1;
      return m;
   endfunction

   function automatic logic [`ECC_MEM_ADDR_W-1:0] pick_written_addr();
      logic [31:0] r;
      r = random_word();
      return written_q[r % written_q.size()];
   endfunction

   // starts 1 ns after an edge and returns 1 ns after the grant edge
   task automatic drive_req(input int p, input mem_req_t r);
      req_data[p] = r;
      req[p]      = 1'b1;
      do @(posedge clk); while (!gnt[p]);
      #1;
      req[p] = 1'b0;
   endtask

   task automatic drive_pair(input mem_req_t r0, input mem_req_t r1);
      req_data[0] = r0;
      req_data[1] = r1;
      req         = '1;
      do @(posedge clk); while (!gnt[0]);
      #1;
      req[0] = 1'b0;
      do @(posedge clk); while (!gnt[1]);
      #1;
      req[1] = 1'b0;
   endtask

   task automatic wait_responses();
      while (exp_q.size() != 0 || exp_valid) @(posedge clk);
      repeat (2) @(posedge clk);
      #1;
   endtask

   task automatic report_test(input string name);
      tests_run++;
      $display("test %0d %s finished with %0d errors", tests_run, name, errors - errors_base);
      errors_base = errors;
   endtask

   always @(posedge clk or negedge rst_l) begin
      if (!rst_l) seen_req <= 1'b0;
      else if (req != '0) seen_req <= 1'b1;
   end

   // writes update the model at their grant and reads queue a response due 3 edges later
   always @(posedge clk or negedge rst_l) begin
      exp_entry_t                    e;
      logic [`ECC_MEM_NUM_PORTS-1:0] g;
      int                            p;
      int unsigned                   flips;
      if (!rst_l) begin
         exp_valid <= 1'b0;
         exp_q.delete();
      end else begin
         g = lowest_request_mask(req);
         if (g != '0) begin
            p = 0;
            for (int i = 0; i < `ECC_MEM_NUM_PORTS; i++) begin
               if (g[i]) p = i;
            end
            if (req_data[p].write) begin
               ref_data[req_data[p].addr] = req_data[p].wdata;
               ref_flip[req_data[p].addr] = req_data[p].flip;
            end else begin
               flips              = $countones(ref_flip[req_data[p].addr]);
               e.due              = cyc + 3;
               e.rsp.port         = port_id_t'(p);
               e.rsp.rdata        = ref_data[req_data[p].addr];
               e.rsp.single_err   = (flips == 1);
               e.rsp.double_err   = (flips == 2);
               e.check_data       = (flips != 2);
               exp_q.push_back(e);
            end
         end
         if (exp_q.size() != 0 && exp_q[0].due == cyc + 1) begin
            exp_valid      <= 1'b1;
            exp_rsp        <= exp_q[0].rsp;
            exp_check_data <= exp_q[0].check_data;
            rsp_count      <= rsp_count + 1;
            void'(exp_q.pop_front());
         end else begin
            exp_valid <= 1'b0;
         end
      end
   end

   a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_l)
      (!seen_req && req == '0) |-> ({gnt, rsp_valid, rsp.single_err, rsp.double_err} == '0))
      else begin
         errors++;
         $display("CHECK FAILED at %0t: {gnt,rsp_valid,single_err,double_err} expected 0, got %b",
                  $time, $sampled({gnt, rsp_valid, rsp.single_err, rsp.double_err}));
      end

   a_gnt_priority: assert property (@(posedge clk) disable iff (!rst_l)
      gnt == lowest_request_mask(req))
      else begin
         errors++;
         $display("CHECK FAILED at %0t: gnt expected %b, got %b", $time,
                  lowest_request_mask($sampled(req)), $sampled(gnt));
      end

   a_rsp_on_time: assert property (@(posedge clk) disable iff (!rst_l)
      exp_valid |-> rsp_valid)
      else begin
         errors++;
         $display("CHECK FAILED at %0t: rsp_valid expected 1, got %b", $time, $sampled(rsp_valid));
      end

   a_rsp_no_extra: assert property (@(posedge clk) disable iff (!rst_l)
      rsp_valid |-> exp_valid)
      else begin
         errors++;
         $display("CHECK FAILED at %0t: rsp_valid expected 0, got 1", $time);
      end

   a_rsp_port: assert property (@(posedge clk) disable iff (!rst_l)
      exp_valid |-> rsp.port == exp_rsp.port)
      else begin
         errors++;
         $display("CHECK FAILED at %0t: rsp.port expected %0d, got %0d", $time,
                  $sampled(exp_rsp.port), $sampled(rsp.port));
      end

   a_rsp_data: assert property (@(posedge clk) disable iff (!rst_l)
      (exp_valid && exp_check_data) |-> rsp.rdata == exp_rsp.rdata)
      else begin
         errors++;
         $display("CHECK FAILED at %0t: rsp.rdata expected %h, got %h", $time,
                  $sampled(exp_rsp.rdata), $sampled(rsp.rdata));
      end

   a_single_flag: assert property (@(posedge clk) disable iff (!rst_l)
      exp_valid |-> rsp.single_err == exp_rsp.single_err)
      else begin
         errors++;
         $display("CHECK FAILED at %0t: rsp.single_err expected %b, got %b", $time,
                  $sampled(exp_rsp.single_err), $sampled(rsp.single_err));
      end

   a_double_flag: assert property (@(posedge clk) disable iff (!rst_l)
      exp_valid |-> rsp.double_err == exp_rsp.double_err)
      else begin
         errors++;
         $display("CHECK FAILED at %0t: rsp.double_err expected %b, got %b", $time,
                  $sampled(exp_rsp.double_err), $sampled(rsp.double_err));
      end

   initial begin
      logic [`ECC_MEM_ADDR_W-1:0] a;
      logic [`ECC_MEM_ADDR_W-1:0] b;
      logic [31:0]                d;
      int unsigned                pa;
      int unsigned                pb;
      rst_l = 1'b0;
      req   = '0;
      for (int i = 0; i < `ECC_MEM_NUM_PORTS; i++) req_data[i] = '0;
      repeat (4) @(posedge clk);
      #1;
      rst_l = 1'b1;

      repeat (6) @(posedge clk);   // quiet outputs before any request
      #1;
      report_test("reset idle");

      for (int i = 0; i < 64; i++) begin
         d = random_word();
         a = d[`ECC_MEM_ADDR_W-1:0];
         d = random_word();
         drive_req(i % 2, build_request(1'b1, a, d, '0));
         written_q.push_back(a);
      end
      foreach (written_q[i]) drive_req(i % 2, build_request(1'b0, written_q[i], '0, '0));
      wait_responses();
      report_test("clean write and read");

      // odd rounds put a write on port 0 ahead of a read of the same word on port 1
      for (int i = 0; i < 24; i++) begin
         a = pick_written_addr();
         b = pick_written_addr();
         d = random_word();
         if (i % 2 == 0) begin
            drive_pair(build_request(1'b0, a, '0, '0), build_request(1'b0, b, '0, '0));
         end else begin
            drive_pair(build_request(1'b1, a, d, '0), build_request(1'b0, a, '0, '0));
         end
      end
      wait_responses();
      report_test("two port priority");

      for (int i = 0; i < CW_W; i++) begin
         d = random_word();
         a = d[`ECC_MEM_ADDR_W-1:0];
         d = random_word();
         drive_req(i % 2, build_request(1'b1, a, d, one_bit_flip(i)));
         drive_req(i % 2, build_request(1'b0, a, '0, '0));
      end
      wait_responses();
      report_test("single bit flips");

      for (int i = 0; i < 40; i++) begin
         d  = random_word();
         a  = d[`ECC_MEM_ADDR_W-1:0];
         pa = random_word() % CW_W;
         pb = (pa + 1 + random_word() % (CW_W - 1)) % CW_W;   // always differs from pa
         d  = random_word();
         drive_req(1, build_request(1'b1, a, d, one_bit_flip(pa) ^ one_bit_flip(pb)));
         drive_req(0, build_request(1'b0, a, '0, '0));
      end
      wait_responses();
      report_test("double bit flips");

      for (int i = 0; i < 32; i++) begin
         d = random_word();
         a = d[`ECC_MEM_ADDR_W-1:0];
         d = random_word();
         drive_req(i % 2, build_request(1'b1, a, d, '0));
         drive_req((i + 1) % 2, build_request(1'b0, a, '0, '0));
      end
      wait_responses();
      report_test("read right after write");

      $display("tests %0d, responses checked %0d, errors %0d", tests_run, rsp_count, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/ecc_mem_pkg.sv
hw/req_arbiter.sv
hw/ecc_store.sv
hw/ecc_correct.sv
hw/ecc_mem_top.sv
verification/ecc_mem_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ecc_mem_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
